//--- sources.f
cam_cfg_pkg.sv
ov5640_reg_table.sv
cam_cfg_sequencer.sv
sccb_writer.sv
cam_cfg_top.sv
cam_cfg_props.sv
tb_cam_cfg.sv

//--- Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_cam_cfg
FILELIST := sources.f
OBJ_DIR  := obj_dir
LOG      := sim.log
FAIL_MSG := Simulation finished: FAIL
PASS_MSG := Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build $(TOP) with $(TOOL), run it and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+1000 > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "no result in $(LOG)"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_cam_cfg.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cam_cfg
   import cam_cfg_pkg::*;
();

   // short quarter period keeps the run fast
   localparam int PHASE = 4;
   // start 2 + 36 slots x 4 + stop 2
   localparam int FRAME_PHASES = 2 + 4 * 9 * 4 + 2;
   localparam int RUN_CYCLES = 20 * FRAME_PHASES * PHASE;
   localparam int RUN_NS = RUN_CYCLES * 40;
   // first run doubled plus partial run and full rerun for the reset test
   localparam int WATCHDOG_NS = 2 * RUN_NS + 2 * RUN_NS + 20_000;
   localparam logic [15:0] EXP_W = 16'd1280;
   localparam logic [15:0] EXP_H = 16'd720;

   logic                   clk_25M = 1'b0;
   logic                   camera_rstn;
   logic                   initial_en;
   logic                   reg_conf_done;
   logic                   scl;
   logic                   sda_oe;
   logic [CFG_INDEX_W-1:0] reg_index;

   // expected writes as {addr, value}
   logic [23:0] exp_tab [20];
   int          err_cnt [1:5];
   // which test a decoder failure counts against
   int          frame_tid;
   int          ack_tid;
   int          done_tid;
   int          seed;

   // bus decoder state
   logic        prev_scl;
   logic        prev_sda;
   logic        prev_done;
   logic        in_frame;
   logic [31:0] shift;
   int          bit_cnt;
   int          frame_cnt;
   int          start_cnt;
   int          ack_cnt;

   cam_cfg_top #(
      .PHASE_CYCLES (PHASE)
   ) UUT (
      .clk_25M       (clk_25M),
      .camera_rstn   (camera_rstn),
      .initial_en    (initial_en),
      .reg_conf_done (reg_conf_done),
      .scl           (scl),
      .sda_oe        (sda_oe),
      .reg_index     (reg_index)
   );

   always #20 clk_25M = ~clk_25M;

   //////////////////////////////////////////////////////////////////////
   // helpers
   //////////////////////////////////////////////////////////////////////

   task automatic load_expected();
      exp_tab[0]  = {16'h3103, 8'h11};
      exp_tab[1]  = {16'h3008, 8'h82};
      exp_tab[2]  = {16'h3008, 8'h42};
      exp_tab[3]  = {16'h3103, 8'h03};
      exp_tab[4]  = {16'h3035, 8'h21};
      exp_tab[5]  = {16'h3036, 8'h69};
      exp_tab[6]  = {16'h3800, 8'h00};
      exp_tab[7]  = {16'h3801, 8'h00};
      exp_tab[8]  = {16'h3802, 8'h00};
      exp_tab[9]  = {16'h3803, 8'hFA};
      exp_tab[10] = {16'h3804, 8'h0A};
      exp_tab[11] = {16'h3805, 8'h3F};
      exp_tab[12] = {16'h3806, 8'h06};
      exp_tab[13] = {16'h3807, 8'hA9};
      // output size with the high byte first
      exp_tab[14] = {16'h3808, EXP_W[15:8]};
      exp_tab[15] = {16'h3809, EXP_W[7:0]};
      exp_tab[16] = {16'h380A, EXP_H[15:8]};
      exp_tab[17] = {16'h380B, EXP_H[7:0]};
      exp_tab[18] = {16'h4300, 8'h60};
      exp_tab[19] = {16'h3008, 8'h02};
   endtask

   task automatic value_error(input int tid, input string name,
                              input logic [31:0] expected, input logic [31:0] actual);
      $display("** Error at %0d ns: %s expected %0h got %0h", $time, name, expected, actual);
      err_cnt[tid] = err_cnt[tid] + 1;
   endtask

   task automatic plain_error(input int tid, input string what);
      $display("test %0d at %0d ns: %s", tid, $time, what);
      err_cnt[tid] = err_cnt[tid] + 1;
   endtask

   task automatic end_test(input int tid, input string name);
      $display("test %0d %s: %s, %0d errors", tid, name,
               (err_cnt[tid] == 0) ? "ok" : "FAILED", err_cnt[tid]);
   endtask

   // called right after a rising edge and checks the outputs while held
   task automatic pulse_reset(input int tid);
      camera_rstn <= 1'b0;
      repeat (2) @(posedge clk_25M);
      @(negedge clk_25M);
      assert (scl === 1'b1) else value_error(tid, "scl", 32'd1, 32'(scl));
      assert (sda_oe === 1'b0) else value_error(tid, "sda_oe", 32'd0, 32'(sda_oe));
      assert (reg_conf_done === 1'b0)
         else value_error(tid, "reg_conf_done", 32'd0, 32'(reg_conf_done));
      assert (reg_index === '0) else value_error(tid, "reg_index", 32'd0, 32'(reg_index));
      @(posedge clk_25M);
      camera_rstn <= 1'b1;
   endtask

   // wait for done and stay a while to catch late starts
   task automatic run_to_done();
      while (reg_conf_done !== 1'b1) @(posedge clk_25M);
      repeat (200) @(posedge clk_25M);
   endtask

   //////////////////////////////////////////////////////////////////////
   // sccb decoder sampling on the falling edge after outputs settle
   //////////////////////////////////////////////////////////////////////

   always @(negedge clk_25M) begin
      if (!camera_rstn) begin
         // aborted frame dropped and the next run counts from 0
         in_frame  = 1'b0;
         bit_cnt   = 0;
         frame_cnt = 0;
         start_cnt = 0;
         ack_cnt   = 0;
      end else if (scl && prev_scl && !prev_sda && sda_oe) begin
         // start condition
         start_cnt = start_cnt + 1;
         assert (!reg_conf_done) else plain_error(done_tid, "start after reg_conf_done");
         assert (int'(reg_index) == frame_cnt)
            else value_error(done_tid, "reg_index", 32'(frame_cnt), 32'(reg_index));
         in_frame = 1'b1;
         bit_cnt  = 0;
         shift    = '0;
      end else if (scl && prev_scl && prev_sda && !sda_oe && in_frame) begin
         // stop condition closes the frame
         assert (frame_cnt < 20) else plain_error(done_tid, "more than 20 frames in one run");
         if (frame_cnt < 20) begin
            assert (bit_cnt == 37)
               else plain_error(frame_tid, $sformatf("frame %0d had %0d scl rises, 37 expected",
                                                     frame_cnt, bit_cnt));
            assert (shift == {8'h78, exp_tab[frame_cnt]})
               else value_error(frame_tid, "sccb frame", {8'h78, exp_tab[frame_cnt]}, shift);
         end
         in_frame  = 1'b0;
         frame_cnt = frame_cnt + 1;
      end else if (!prev_scl && scl && in_frame) begin
         // 36 slot clocks come first and the 37th rise belongs to the stop
         if (bit_cnt < 36) begin
            // ninth slot of each byte is the released ack bit
            if (bit_cnt % 9 == 8) begin
               ack_cnt = ack_cnt + 1;
               assert (!sda_oe) else value_error(ack_tid, "sda_oe", 32'd0, 32'(sda_oe));
            end else begin
               shift = {shift[30:0], ~sda_oe};
            end
         end
         bit_cnt = bit_cnt + 1;
      end
      if (camera_rstn && reg_conf_done && !prev_done) begin
         assert (frame_cnt == 20)
            else value_error(done_tid, "stop count at reg_conf_done", 32'd20, 32'(frame_cnt));
      end
      assert (!(camera_rstn && prev_done && !reg_conf_done))
         else plain_error(done_tid, "reg_conf_done fell without a reset");
      prev_scl  = scl;
      prev_sda  = sda_oe;
      prev_done = reg_conf_done;
   end

   //////////////////////////////////////////////////////////////////////
   // stimulus
   //////////////////////////////////////////////////////////////////////

   initial begin
      int cut;
      int failed;
      int errs;
      int prop_fails;
      load_expected();
      seed      = 78;
      frame_tid = 2;
      ack_tid   = 3;
      done_tid  = 4;
      for (int i = 1; i <= 5; i++) begin
         err_cnt[i] = 0;
      end
      camera_rstn = 1'b0;
      initial_en  = 1'b0;
      repeat (2) @(posedge clk_25M);
      camera_rstn <= 1'b1;

      // bus must stay quiet with initial_en low
      repeat (50) begin
         @(negedge clk_25M);
         assert (scl === 1'b1) else value_error(1, "scl", 32'd1, 32'(scl));
         assert (sda_oe === 1'b0) else value_error(1, "sda_oe", 32'd0, 32'(sda_oe));
         assert (reg_conf_done === 1'b0)
            else value_error(1, "reg_conf_done", 32'd0, 32'(reg_conf_done));
      end
      assert (start_cnt == 0) else plain_error(1, "start condition while initial_en was low");
      end_test(1, "reset and idle");

      // full table
      @(posedge clk_25M);
      initial_en <= 1'b1;
      run_to_done();
      assert (frame_cnt == 20) else value_error(2, "frame count", 32'd20, 32'(frame_cnt));
      end_test(2, "frame content");
      assert (ack_cnt == 80) else value_error(3, "ack slot count", 32'd80, 32'(ack_cnt));
      end_test(3, "acknowledge slot");
      assert (int'(reg_index) == 20) else value_error(4, "reg_index", 32'd20, 32'(reg_index));
      assert (reg_conf_done === 1'b1)
         else value_error(4, "reg_conf_done", 32'd1, 32'(reg_conf_done));
      end_test(4, "completion");

      // new run cut short by a reset and then run again to the end
      frame_tid = 5;
      ack_tid   = 5;
      done_tid  = 5;
      @(posedge clk_25M);
      pulse_reset(5);
      cut = 100 + int'(($random(seed) & 32'h7fff_ffff) % (RUN_CYCLES - 200));
      repeat (cut) @(posedge clk_25M);
      pulse_reset(5);
      run_to_done();
      assert (frame_cnt == 20) else value_error(5, "frame count", 32'd20, 32'(frame_cnt));
      end_test(5, "restart after reset");

      failed     = 0;
      errs       = 0;
      prop_fails = UUT.u_writer.u_props.fail_cnt;
      for (int i = 1; i <= 5; i++) begin
         errs = errs + err_cnt[i];
         if (err_cnt[i] != 0) begin
            failed = failed + 1;
         end
      end
      $display("tests 5, failed %0d, check errors %0d, property failures %0d",
               failed, errs, prop_fails);
      if (errs == 0 && prop_fails == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

   // hang guard
   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired after %0d ns, reg_conf_done never came", WATCHDOG_NS);
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

//--- cam_cfg_props.sv
`timescale 1ns/1ps
`default_nettype none

module cam_cfg_props (
   input wire logic       clk_25M,
   input wire logic       camera_rstn,
   input wire logic [1:0] wr_state,
   input wire logic       scl,
   input wire logic       sda_oe,
   input wire logic       frame_done
);

   // writer encoding, idle is the first state
   localparam logic [1:0] WR_IDLE = 2'd0;

   // failed properties so far
   int fail_cnt = 0;

   //////////////////////////////////////////////////////////////////////
   // sda under a high scl
   //////////////////////////////////////////////////////////////////////

   // rise with scl high only when leaving idle, i.e. start condition
   a_start_only: assert property (@(posedge clk_25M) disable iff (!camera_rstn)
      (scl && $past(scl) && $rose(sda_oe)) |-> ($past(wr_state) == WR_IDLE))
      else begin
         $error("sda_oe rose under high scl outside a start condition");
         fail_cnt = fail_cnt + 1;
      end

   // fall with scl high only on the way back to idle, i.e. stop condition
   a_stop_only: assert property (@(posedge clk_25M) disable iff (!camera_rstn)
      (scl && $past(scl) && $fell(sda_oe)) |-> (wr_state == WR_IDLE && frame_done))
      else begin
         $error("sda_oe fell under high scl outside a stop condition");
         fail_cnt = fail_cnt + 1;
      end

   //////////////////////////////////////////////////////////////////////
   // idle line and done pulse
   //////////////////////////////////////////////////////////////////////

   a_idle_scl: assert property (@(posedge clk_25M) disable iff (!camera_rstn)
      (wr_state == WR_IDLE) |-> scl)
      else begin
         $error("scl low while the writer is idle");
         fail_cnt = fail_cnt + 1;
      end

   // one cycle wide
   a_done_pulse: assert property (@(posedge clk_25M) disable iff (!camera_rstn)
      frame_done |=> !frame_done)
      else begin
         $error("frame_done held for more than one cycle");
         fail_cnt = fail_cnt + 1;
      end

endmodule

bind sccb_writer cam_cfg_props u_props (
   .clk_25M     (clk_25M),
   .camera_rstn (camera_rstn),
   .wr_state    (state),
   .scl         (scl),
   .sda_oe      (sda_oe),
   .frame_done  (frame_done)
);

`default_nettype wire

//--- cam_cfg_top.sv
`timescale 1ns/1ps
`default_nettype none

module cam_cfg_top
   import cam_cfg_pkg::*;
#(
   parameter int PHASE_CYCLES = SCCB_PHASE_CYCLES
) (
   input  wire logic              clk_25M,
   input  wire logic              camera_rstn,
   input  wire logic              initial_en,
   output logic                   reg_conf_done,
   output logic                   scl,
   output logic                   sda_oe,
   output logic [CFG_INDEX_W-1:0] reg_index
);

   cfg_entry_t  entry;
   sccb_frame_u frame;
   logic        start;
   logic        frame_done;

   // index -> address/value, same cycle
   ov5640_reg_table u_table (
      .reg_index (reg_index),
      .entry     (entry)
   );

   // walks the table, one write at a time
   cam_cfg_sequencer u_seq (
      .clk_25M       (clk_25M),
      .camera_rstn   (camera_rstn),
      .initial_en    (initial_en),
      .entry         (entry),
      .frame_done    (frame_done),
      .reg_index     (reg_index),
      .frame         (frame),
      .start         (start),
      .reg_conf_done (reg_conf_done)
   );

   // sccb line driver, sda as open-drain enable
   sccb_writer #(
      .PHASE_CYCLES (PHASE_CYCLES)
   ) u_writer (
      .clk_25M     (clk_25M),
      .camera_rstn (camera_rstn),
      .start       (start),
      .frame       (frame),
      .scl         (scl),
      .sda_oe      (sda_oe),
      .frame_done  (frame_done)
   );

endmodule

`default_nettype wire

//--- sccb_writer.sv
`timescale 1ns/1ps
`default_nettype none

module sccb_writer
   import cam_cfg_pkg::*;
#(
   parameter int PHASE_CYCLES = SCCB_PHASE_CYCLES
) (
   input  wire logic  clk_25M,
   input  wire logic  camera_rstn,
   input  wire logic  start,
   input  wire sccb_frame_u frame,
   output logic       scl,
   output logic       sda_oe,
   output logic       frame_done
);

   localparam int DIV_W     = $clog2(PHASE_CYCLES + 1);
   localparam int SLOT_LAST = SCCB_BIT_SLOTS - 1;

   typedef enum logic [1:0] {
      S_IDLE,
      S_START,
      S_BITS,
      S_STOP
   } wr_state_t;

   wr_state_t   state;
   wr_state_t   state_n;
   logic [DIV_W-1:0] div_cnt;
   logic        tick;
   // byte_idx counts down from bytes[3]
   logic [1:0]  byte_idx;
   logic [1:0]  byte_n;
   logic [3:0]  slot_cnt;
   logic [3:0]  slot_n;
   logic [1:0]  phase;
   logic [1:0]  phase_n;
   logic [2:0]  bit_sel;
   logic        bit_n;
   logic        scl_n;
   logic        sda_n;
   sccb_frame_u frame_q;

   //////////////////////////////////////////////////////////////////////
   // phase tick
   //////////////////////////////////////////////////////////////////////

   // one tick per quarter scl period while busy
   assign tick = (state != S_IDLE) && (div_cnt == DIV_W'(PHASE_CYCLES - 1));

   always_ff @(posedge clk_25M) begin
      if (!camera_rstn) begin
         div_cnt <= '0;
      end else if (state == S_IDLE || tick) begin
         div_cnt <= '0;
      end else begin
         div_cnt <= div_cnt + 1'b1;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // position through start cond, 4 x 9 slots of 4 phases and stop cond
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      state_n = state;
      byte_n  = byte_idx;
      slot_n  = slot_cnt;
      phase_n = phase;
      case (state)
         S_IDLE: begin
            // start ignored while a write runs
            if (start) begin
               state_n = S_START;
               byte_n  = 2'(SCCB_FRAME_BYTES - 1);
               slot_n  = '0;
               phase_n = '0;
            end
         end
         S_START: begin
            if (tick) begin
               phase_n = phase + 1'b1;
               if (phase == 2'd1) begin
                  state_n = S_BITS;
                  phase_n = '0;
               end
            end
         end
         S_BITS: begin
            if (tick) begin
               // 2-bit phase wraps 3 -> 0 by itself
               phase_n = phase + 1'b1;
               if (phase == 2'd3) begin
                  if (slot_cnt == 4'(SLOT_LAST)) begin
                     slot_n = '0;
                     if (byte_idx == 2'd0) begin
                        state_n = S_STOP;
                     end else begin
                        byte_n = byte_idx - 1'b1;
                     end
                  end else begin
                     slot_n = slot_cnt + 1'b1;
                  end
               end
            end
         end
         S_STOP: begin
            if (tick) begin
               phase_n = phase + 1'b1;
               if (phase == 2'd1) begin
                  state_n = S_IDLE;
                  phase_n = '0;
               end
            end
         end
         default: state_n = S_IDLE;
      endcase
   end

   // msb first within a byte
   assign bit_sel = 3'd7 - slot_n[2:0];
   assign bit_n   = frame_q.bytes[byte_n][bit_sel];

   // line levels for the next position
   always_comb begin
      scl_n = 1'b1;
      sda_n = 1'b0;
      case (state_n)
         // sda pulled low with scl high
         S_START: sda_n = 1'b1;
         S_BITS: begin
            // low in phases 0/1 and high in 2/3
            scl_n = phase_n[1];
            // 9th slot released since ack is not sampled
            sda_n = (slot_n == 4'(SLOT_LAST)) ? 1'b0 : ~bit_n;
         end
         // sda held low while scl goes low then high and released on exit
         S_STOP: begin
            scl_n = phase_n[0];
            sda_n = 1'b1;
         end
         default: begin
            scl_n = 1'b1;
            sda_n = 1'b0;
         end
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // registers
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk_25M) begin
      if (!camera_rstn) begin
         state      <= S_IDLE;
         byte_idx   <= '0;
         slot_cnt   <= '0;
         phase      <= '0;
         scl        <= 1'b1;
         sda_oe     <= 1'b0;
         frame_done <= 1'b0;
      end else begin
         state      <= state_n;
         byte_idx   <= byte_n;
         slot_cnt   <= slot_n;
         phase      <= phase_n;
         scl        <= scl_n;
         sda_oe     <= sda_n;
         // end of the last stop phase
         frame_done <= (state == S_STOP) && (phase == 2'd1) && tick;
      end
   end

   // capture the frame at start
   always_ff @(posedge clk_25M) begin
      if (state == S_IDLE && start) begin
         frame_q <= frame;
      end
   end

endmodule

`default_nettype wire

//--- cam_cfg_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module cam_cfg_sequencer
   import cam_cfg_pkg::*;
(
   input  wire logic                   clk_25M,
   input  wire logic                   camera_rstn,
   input  wire logic                   initial_en,
   input  wire cfg_entry_t             entry,
   input  wire logic                   frame_done,
   output logic [CFG_INDEX_W-1:0]      reg_index,
   output sccb_frame_u                 frame,
   output logic                        start,
   output logic                        reg_conf_done
);

   // launch doubles as idle before the first write
   typedef enum logic [1:0] {
      S_LAUNCH,
      S_WAIT,
      S_ADVANCE
   } step_t;

   step_t       step;
   sccb_frame_u next_frame;
   logic        more_regs;

   // still inside the table
   assign more_regs = (reg_index < CFG_INDEX_W'(CFG_NUM_REGS));

   // frame for the current entry with the device id in front
   always_comb begin
      next_frame.fields.dev_id  = SCCB_DEV_ID;
      next_frame.fields.addr_hi = entry.reg_addr[15:8];
      next_frame.fields.addr_lo = entry.reg_addr[7:0];
      next_frame.fields.data    = entry.reg_val;
   end

   //////////////////////////////////////////////////////////////////////
   // step control
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk_25M) begin
      if (!camera_rstn) begin
         step          <= S_LAUNCH;
         start         <= 1'b0;
         reg_index     <= '0;
         reg_conf_done <= 1'b0;
      end else begin
         // single-cycle start pulse
         start <= 1'b0;
         case (step)
            S_LAUNCH: begin
               // hold here until enabled and for good once done
               if (initial_en && !reg_conf_done && more_regs) begin
                  start <= 1'b1;
                  step  <= S_WAIT;
               end
            end
            S_WAIT: begin
               // wait for the writer to finish the one outstanding write
               if (frame_done) begin
                  reg_index <= reg_index + 1'b1;
                  step      <= S_ADVANCE;
               end
            end
            S_ADVANCE: begin
               // index already moved so launch the next write or finish
               if (more_regs) begin
                  start <= 1'b1;
                  step  <= S_WAIT;
               end else begin
                  reg_conf_done <= 1'b1;
                  step          <= S_LAUNCH;
               end
            end
            default: step <= S_LAUNCH;
         endcase
      end
   end

   // frame loads with start and stays put during the write
   always_ff @(posedge clk_25M) begin
      if ((step == S_LAUNCH && initial_en && !reg_conf_done && more_regs) ||
          (step == S_ADVANCE && more_regs)) begin
         frame <= next_frame;
      end
   end

endmodule

`default_nettype wire

//--- ov5640_reg_table.sv
`timescale 1ns/1ps
`default_nettype none

module ov5640_reg_table
   import cam_cfg_pkg::*;
(
   input  wire logic [CFG_INDEX_W-1:0] reg_index,
   output cfg_entry_t                  entry
);

   //////////////////////////////////////////////////////////////////////
   // write list, sent in index order
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      case (reg_index)
         // system control
         // clock from pad, then soft reset, then power down for setup
         5'd0:  entry = '{16'h3103, 8'h11};
         5'd1:  entry = '{16'h3008, 8'h82};
         5'd2:  entry = '{16'h3008, 8'h42};
         // clock back to the pll path
         5'd3:  entry = '{16'h3103, 8'h03};

         // pll, 24 MHz in
         5'd4:  entry = '{16'h3035, 8'h21};
         5'd5:  entry = '{16'h3036, 8'h69};

         // sensor window start x/y
         5'd6:  entry = '{16'h3800, 8'h00};
         5'd7:  entry = '{16'h3801, 8'h00};
         5'd8:  entry = '{16'h3802, 8'h00};
         5'd9:  entry = '{16'h3803, 8'hFA};
         // sensor window end x/y
         5'd10: entry = '{16'h3804, 8'h0A};
         5'd11: entry = '{16'h3805, 8'h3F};
         5'd12: entry = '{16'h3806, 8'h06};
         5'd13: entry = '{16'h3807, 8'hA9};

         // output size from the display size
         // high byte first, as the sensor expects
         5'd14: entry = '{16'h3808, DISPLAY_H[15:8]};
         5'd15: entry = '{16'h3809, DISPLAY_H[7:0]};
         5'd16: entry = '{16'h380A, DISPLAY_V[15:8]};
         5'd17: entry = '{16'h380B, DISPLAY_V[7:0]};

         // rgb565 output
         5'd18: entry = '{16'h4300, 8'h60};

         // leave power down, start streaming
         5'd19: entry = '{16'h3008, 8'h02};

         // past the end, sequencer stops before using this
         default: entry = '{16'hFFFF, 8'hFF};
      endcase
   end

endmodule

`default_nettype wire

//--- cam_cfg_pkg.sv
`default_nettype none

package cam_cfg_pkg;

   //////////////////////////////////////////////////////////////////////
   // output size
   //////////////////////////////////////////////////////////////////////

   // active width and height sent to 3808..380b
   localparam logic [15:0] DISPLAY_H = 16'd1280;
   localparam logic [15:0] DISPLAY_V = 16'd720;

   //////////////////////////////////////////////////////////////////////
   // register table
   //////////////////////////////////////////////////////////////////////

   // entries actually written to the sensor
   localparam int CFG_NUM_REGS = 20;
   // index must also hold CFG_NUM_REGS itself (end marker)
   localparam int CFG_INDEX_W = 5;

   //////////////////////////////////////////////////////////////////////
   // sccb bus
   //////////////////////////////////////////////////////////////////////

   // ov5640 write address, 8-bit form
   localparam logic [7:0] SCCB_DEV_ID = 8'h78;
   // quarter scl period in clk_25M cycles
   // 1250 gives 5 kHz scl, well under the sensor limit
   localparam int SCCB_PHASE_CYCLES = 1250;
   // id, addr hi, addr lo, data
   localparam int SCCB_FRAME_BYTES = 4;
   // 8 data bits plus the don't-care 9th bit
   localparam int SCCB_BIT_SLOTS = 9;

   //////////////////////////////////////////////////////////////////////
   // types
   //////////////////////////////////////////////////////////////////////

   // one table row
   typedef struct packed {
      logic [15:0] reg_addr;
      logic [7:0]  reg_val;
   } cfg_entry_t;

   // three-phase write, first byte on the wire is the msb field
   typedef struct packed {
      logic [7:0] dev_id;
      logic [7:0] addr_hi;
      logic [7:0] addr_lo;
      logic [7:0] data;
   } sccb_write_t;

   // sequencer fills the fields, serializer walks the bytes
   // bytes[3] is dev_id and goes out first
   typedef union packed {
      sccb_write_t                            fields;
      logic [SCCB_FRAME_BYTES-1:0][7:0]       bytes;
   } sccb_frame_u;

endpackage

`default_nettype wire
